// File: test/matchedFilterCases.txt
# Each record starts with name newCoeff extraStart.
# Then 8 coefficient pairs re im for taps 0 to 7 and 24 samples.
# Then 24 expected L1 magnitudes in output order.
# newCoeff 0 keeps the taps of the previous case and extraStart 1 pulses start mid-run.

# Impulse of 64 through taps (2,0) and (0,1).
impulse 1 0
2 0  0 1  0 0  0 0  0 0  0 0  0 0  0 0
64 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0
28 14 82 169 146 41 28 14 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0

# Mixed signs with taps (-3,2) and (1,-1) and a sample at the block end.
mixedSign 1 0
-3 2  0 0  0 0  0 0  0 0  1 -1  0 0  0 0
128 -64 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 64
140 70 410 599 402 149 112 94 256 164 82 56
28 0 0 0 0 0 0 0 0 0 0 70

# Previous taps kept and history cleared, with an inexact Hilbert shift.
reuseTaps 0 0
0 0  0 0  0 0  0 0  0 0  0 0  0 0  0 0
100 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0
110 0 325 500 320 44 105 130 200 128 0 42
0 0 0 0 0 0 0 0 0 0 0 0

# New taps (1,0) and (0,-1) with a second start while busy.
startWhileBusy 1 1
1 0  0 0  0 0  0 0  0 0  0 0  0 0  0 -1
-128 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0
28 0 82 128 82 0 28 28 0 82 128 82
0 28 0 0 0 0 0 0 0 0 0 0

// File: matchedFilter.f
common/matchedFilterPkg.sv
common/sampleBus.sv
rtl/blockStore.sv
rtl/matchedFilterControl.sv
rtl/hilbertTransform.sv
complexFir/complexFir.sv
rtl/magnitudeDetector.sv
rtl/matchedFilter.sv
test/matchedFilter_sva.sv
test/matchedFilterTb.sv

// File: Makefile
TOP := matchedFilterTb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f matchedFilter.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: test/matchedFilterTb.sv
`timescale 1ns/1ps

module matchedFilterTb import matchedFilterPkg::*; ();

	localparam int COEFF_LENGTH = 8;
	localparam int DATA_LENGTH = 24;
	localparam int MAX_CASES = 8;
	localparam int SETTLE_CYCLES = 5;
	localparam int FIELDS_PER_CASE = 2 + 2 * COEFF_LENGTH + 2 * DATA_LENGTH;

	logic clock = 1'b0;
	logic rst;
	logic start;
	logic coeffWrite;
	logic signed [DATA_WIDTH-1:0] coeffRe;
	logic signed [DATA_WIDTH-1:0] coeffIm;
	logic sampleWrite;
	logic signed [DATA_WIDTH-1:0] sample;
	logic [MAG_WIDTH-1:0] magnitude;
	logic outValid;
	logic outLast;
	logic busy;
	logic done;

	// One record per case as read from the case file.
	string caseName [MAX_CASES];
	int newCoeff [MAX_CASES];
	int extraStart [MAX_CASES];
	int coeffTable [MAX_CASES][2*COEFF_LENGTH];
	int sampleTable [MAX_CASES][DATA_LENGTH];
	int expectTable [MAX_CASES][DATA_LENGTH];
	int caseCount;

	logic [MAG_WIDTH-1:0] received [$];
	int lastIndex;
	int doneCount;
	logic busyAtDone;
	logic lastBefore = 1'b0;
	logic doneAfterLast;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;

	matchedFilter #(
		.COEFF_LENGTH (COEFF_LENGTH),
		.DATA_LENGTH  (DATA_LENGTH)
	) matchedFilter_inst (
		.clock       (clock),
		.rst         (rst),
		.start       (start),
		.coeffWrite  (coeffWrite),
		.coeffRe     (coeffRe),
		.coeffIm     (coeffIm),
		.sampleWrite (sampleWrite),
		.sample      (sample),
		.magnitude   (magnitude),
		.outValid    (outValid),
		.outLast     (outLast),
		.busy        (busy),
		.done        (done)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout after %0d clock cycles, the DUT never finished its run.", cycleCount);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// Outputs are collected half a cycle after the edge that updates them.
	always @(negedge clock) begin
		if (!rst && outValid) begin
			received.push_back(magnitude);
			if (outLast) begin
				lastIndex = received.size() - 1;
			end
		end
		// Done belongs in the cycle right after the last magnitude.
		if (!rst && done) begin
			doneCount++;
			busyAtDone = busy;
			doneAfterLast = lastBefore;
		end
		lastBefore = !rst && outLast;
	end

	task automatic checkValue(input string signalName, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("CHECK FAILED at %0d ns: %s expected %0d, actual %0d",
				$time, signalName, expected, actual);
		end
	endtask

	task automatic readCases(output bit ok);
		int fd;
		int status;
		int fields;
		string token;
		logic [8*120-1:0] commentLine;
		ok = 1'b0;
		caseCount = 0;
		fd = $fopen("test/matchedFilterCases.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (caseCount < MAX_CASES) begin
				status = $fscanf(fd, "%s", token);
				if (status != 1) begin
					break;
				end
				if (token == "#") begin
					status = $fgets(commentLine, fd);
				end else begin
					caseName[caseCount] = token;
					fields = $fscanf(fd, "%d %d", newCoeff[caseCount], extraStart[caseCount]);
					for (int k = 0; k < 2 * COEFF_LENGTH; k++) begin
						fields += $fscanf(fd, "%d", coeffTable[caseCount][k]);
					end
					for (int k = 0; k < DATA_LENGTH; k++) begin
						fields += $fscanf(fd, "%d", sampleTable[caseCount][k]);
					end
					for (int k = 0; k < DATA_LENGTH; k++) begin
						fields += $fscanf(fd, "%d", expectTable[caseCount][k]);
					end
					if (fields != FIELDS_PER_CASE) begin
						$display("Case %s in the case file is incomplete.", token);
						ok = 1'b0;
						break;
					end
					caseCount++;
				end
			end
			$fclose(fd);
		end
		if (caseCount == 0) begin
			ok = 1'b0;
		end
	endtask

	task automatic loadCoefficients(input int n);
		for (int k = 0; k < COEFF_LENGTH; k++) begin
			@(posedge clock);
			#1;
			coeffWrite = 1'b1;
			coeffRe = DATA_WIDTH'(coeffTable[n][2*k]);
			coeffIm = DATA_WIDTH'(coeffTable[n][2*k+1]);
		end
		@(posedge clock);
		#1;
		coeffWrite = 1'b0;
	endtask

	task automatic loadSamples(input int n);
		for (int k = 0; k < DATA_LENGTH; k++) begin
			@(posedge clock);
			#1;
			sampleWrite = 1'b1;
			sample = DATA_WIDTH'(sampleTable[n][k]);
		end
		@(posedge clock);
		#1;
		sampleWrite = 1'b0;
	endtask

	task automatic pulseStart();
		@(posedge clock);
		#1;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	task automatic checkResetState();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int k = 0; k < 3; k++) begin
			@(negedge clock);
			checkValue("outValid", 0, 64'(outValid));
			checkValue("busy", 0, 64'(busy));
			checkValue("done", 0, 64'(done));
		end
		$display("Reset test finished with %0d errors", errorCount - errorsBefore);
	endtask

	task automatic runCase(input int n);
		int errorsBefore;
		errorsBefore = errorCount;
		received.delete();
		lastIndex = -1;
		doneCount = 0;
		doneAfterLast = 1'b0;
		if (newCoeff[n] != 0) begin
			loadCoefficients(n);
		end
		loadSamples(n);
		pulseStart();
		if (extraStart[n] != 0) begin
			// By now the FSM streams samples, so this start must be ignored.
			repeat (COEFF_LENGTH + 4) @(posedge clock);
			#1;
			checkValue("busy before second start", 1, 64'(busy));
			pulseStart();
		end
		while (doneCount == 0) begin
			@(posedge clock);
			#1;
		end
		repeat (SETTLE_CYCLES) @(posedge clock);
		#1;
		checkValue("busy at done", 0, 64'(busyAtDone));
		checkValue("busy after done", 0, 64'(busy));
		checkValue("done pulses", 1, 64'(doneCount));
		checkValue("outLast before done", 1, 64'(doneAfterLast));
		checkValue("outValid count", DATA_LENGTH, 64'(received.size()));
		checkValue("outLast index", DATA_LENGTH - 1, 64'(lastIndex));
		for (int k = 0; k < DATA_LENGTH && k < received.size(); k++) begin
			checkValue($sformatf("magnitude[%0d]", k), 64'(expectTable[n][k]), 64'(received[k]));
		end
		$display("Case %s finished with %0d errors", caseName[n], errorCount - errorsBefore);
	endtask

	initial begin
		bit fileOk;
		rst = 1'b1;
		start = 1'b0;
		coeffWrite = 1'b0;
		coeffRe = '0;
		coeffIm = '0;
		sampleWrite = 1'b0;
		sample = '0;
		readCases(fileOk);
		if (!fileOk) begin
			$display("The case file test/matchedFilterCases.txt is missing or malformed.");
			$display("Simulation finished: FAIL");
			$finish;
		end else begin
			// Each case needs its loads, the run itself and a short settle time.
			cycleLimit = caseCount * (COEFF_LENGTH + DATA_LENGTH + 40) + 100;
			repeat (3) @(posedge clock);
			#1;
			rst = 1'b0;
			checkResetState();
			for (int n = 0; n < caseCount; n++) begin
				runCase(n);
			end
			$display("Totals: %0d cases, %0d checks, %0d errors", caseCount, checkCount, errorCount);
			if (errorCount == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

endmodule

// File: test/matchedFilter_sva.sv
`timescale 1ns/1ps

// Protocol checks on the control FSM.
module controlAssertions import matchedFilterPkg::*; (
	input logic clock,
	input logic rst,
	input mfState_t state,
	input logic busy,
	input logic done,
	input logic tapLoad
);

	// A run ends with exactly one done cycle.
	doneSinglePulse: assert property (@(posedge clock) disable iff (rst)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	idleNotBusy: assert property (@(posedge clock) disable iff (rst)
		(state == IDLE) |-> !busy)
		else $error("busy is high while the control FSM is idle");

	// The taps may only shift while coefficients are copied
	tapLoadInTransfer: assert property (@(posedge clock) disable iff (rst)
		tapLoad |-> (state == TRANSFER_COEFF))
		else $error("tapLoad is high outside TRANSFER_COEFF");

endmodule

bind matchedFilterControl controlAssertions controlChecks (
	.clock   (clock),
	.rst     (rst),
	.state   (state),
	.busy    (busy),
	.done    (done),
	.tapLoad (tapLoad)
);

// File: rtl/matchedFilter.sv
`timescale 1ns/1ps

module matchedFilter import matchedFilterPkg::*; #(
	parameter int COEFF_LENGTH = 8,
	parameter int DATA_LENGTH = 24
)(
	input  logic clock,
	input  logic rst,
	input  logic start,
	input  logic coeffWrite,
	input  logic signed [DATA_WIDTH-1:0] coeffRe,
	input  logic signed [DATA_WIDTH-1:0] coeffIm,
	input  logic sampleWrite,
	input  logic signed [DATA_WIDTH-1:0] sample,
	output logic [MAG_WIDTH-1:0] magnitude,
	output logic outValid,
	output logic outLast,
	output logic busy,
	output logic done
);

	logic coeffReadEnable;
	logic [addrWidth(COEFF_LENGTH)-1:0] coeffReadAddress;
	logic sampleReadEnable;
	logic [addrWidth(DATA_LENGTH)-1:0] sampleReadAddress;
	logic tapLoad;
	logic sampleStrobe;
	logic sampleLast;
	coeffPair_t coeffWord;
	coeffPair_t coeffRead;
	logic signed [DATA_WIDTH-1:0] sampleRead;

	assign coeffWord = '{re: coeffRe, im: coeffIm};

	sampleBus #(.WIDTH(HT_WIDTH)) analyticBus ();
	sampleBus #(.WIDTH(ACC_WIDTH)) filteredBus ();

	matchedFilterControl #(
		.COEFF_LENGTH (COEFF_LENGTH),
		.DATA_LENGTH  (DATA_LENGTH)
	) control (
		.clock             (clock),
		.rst               (rst),
		.start             (start),
		.outLast           (outLast),
		.coeffReadEnable   (coeffReadEnable),
		.coeffReadAddress  (coeffReadAddress),
		.sampleReadEnable  (sampleReadEnable),
		.sampleReadAddress (sampleReadAddress),
		.tapLoad           (tapLoad),
		.sampleStrobe      (sampleStrobe),
		.sampleLast        (sampleLast),
		.busy              (busy),
		.done              (done)
	);

	// Host writes are dropped while a run is in progress.
	blockStore #(
		.LENGTH    (COEFF_LENGTH),
		.payload_t (coeffPair_t)
	) coeffStore (
		.clock       (clock),
		.rst         (rst),
		.write       (coeffWrite && !busy),
		.writeData   (coeffWord),
		.readEnable  (coeffReadEnable),
		.readAddress (coeffReadAddress),
		.readData    (coeffRead),
		.clear       (done)
	);

	blockStore #(
		.LENGTH    (DATA_LENGTH),
		.payload_t (logic signed [DATA_WIDTH-1:0])
	) sampleStore (
		.clock       (clock),
		.rst         (rst),
		.write       (sampleWrite && !busy),
		.writeData   (sample),
		.readEnable  (sampleReadEnable),
		.readAddress (sampleReadAddress),
		.readData    (sampleRead),
		.clear       (done)
	);

	hilbertTransform hilbert (
		.clock    (clock),
		.rst      (rst),
		.strobe   (sampleStrobe),
		.last     (sampleLast),
		.sample   (sampleRead),
		.analytic (analyticBus.producer)
	);

	complexFir #(
		.COEFF_LENGTH (COEFF_LENGTH)
	) fir (
		.clock   (clock),
		.rst     (rst),
		.tapLoad (tapLoad),
		.coeff   (coeffRead),
		.inBus   (analyticBus.consumer),
		.outBus  (filteredBus.producer)
	);

	magnitudeDetector detector (
		.clock     (clock),
		.rst       (rst),
		.inBus     (filteredBus.consumer),
		.magnitude (magnitude),
		.outValid  (outValid),
		.outLast   (outLast)
	);

endmodule

// File: rtl/magnitudeDetector.sv
`timescale 1ns/1ps

module magnitudeDetector import matchedFilterPkg::*; (
	input  logic clock,
	input  logic rst,
	sampleBus.consumer inBus,
	output logic [MAG_WIDTH-1:0] magnitude,
	output logic outValid,
	output logic outLast
);

	logic [ACC_WIDTH-1:0] absRe;
	logic [ACC_WIDTH-1:0] absIm;

	// Unsigned results, so the most negative input still gives the right value.
	assign absRe = inBus.re[ACC_WIDTH-1] ? -inBus.re : inBus.re;
	assign absIm = inBus.im[ACC_WIDTH-1] ? -inBus.im : inBus.im;

	always_ff @(posedge clock) begin
		if (rst) begin
			outValid <= 1'b0;
			outLast <= 1'b0;
		end else begin
			outValid <= inBus.valid;
			outLast <= inBus.valid && inBus.last;
		end
	end

	always_ff @(posedge clock) begin
		if (inBus.valid) begin
			magnitude <= MAG_WIDTH'(absRe) + MAG_WIDTH'(absIm);
		end
	end

endmodule

// File: complexFir/complexFir.sv
`timescale 1ns/1ps

module complexFir import matchedFilterPkg::*; #(
	parameter int COEFF_LENGTH = 8
)(
	input  logic clock,
	input  logic rst,
	input  logic tapLoad,
	input  coeffPair_t coeff,
	sampleBus.consumer inBus,
	sampleBus.producer outBus
);

	localparam int PROD_WIDTH = DATA_WIDTH + HT_WIDTH + 1;

	coeffPair_t taps [COEFF_LENGTH];
	// Only the older samples are stored. The newest comes straight from the input bus.
	logic signed [HT_WIDTH-1:0] lineRe [COEFF_LENGTH-1];
	logic signed [HT_WIDTH-1:0] lineIm [COEFF_LENGTH-1];
	logic signed [HT_WIDTH-1:0] windowRe [COEFF_LENGTH];
	logic signed [HT_WIDTH-1:0] windowIm [COEFF_LENGTH];
	logic signed [PROD_WIDTH-1:0] prodRe [COEFF_LENGTH];
	logic signed [PROD_WIDTH-1:0] prodIm [COEFF_LENGTH];
	logic signed [ACC_WIDTH-1:0] sumRe;
	logic signed [ACC_WIDTH-1:0] sumIm;
	logic awaitingStart;
	logic prodValid;
	logic prodLast;

	// Window element k is input n-k. History reads as zero on the first sample of a block.
	always_comb begin
		windowRe[0] = inBus.re;
		windowIm[0] = inBus.im;
		for (int k = 1; k < COEFF_LENGTH; k++) begin
			windowRe[k] = awaitingStart ? '0 : lineRe[k-1];
			windowIm[k] = awaitingStart ? '0 : lineIm[k-1];
		end
	end

	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < COEFF_LENGTH; k++) begin
			sumRe = sumRe + prodRe[k];
			sumIm = sumIm + prodIm[k];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			awaitingStart <= 1'b1;
			prodValid <= 1'b0;
			prodLast <= 1'b0;
			outBus.valid <= 1'b0;
			outBus.last <= 1'b0;
		end else begin
			if (inBus.valid) begin
				awaitingStart <= inBus.last;
			end
			prodValid <= inBus.valid;
			prodLast <= inBus.valid && inBus.last;
			outBus.valid <= prodValid;
			outBus.last <= prodValid && prodLast;
		end
	end

	always_ff @(posedge clock) begin
		// Coefficients enter at the top and move down, so tap k ends up holding coefficient k.
		if (tapLoad) begin
			for (int k = 0; k < COEFF_LENGTH - 1; k++) begin
				taps[k] <= taps[k+1];
			end
			taps[COEFF_LENGTH-1] <= coeff;
		end
		if (inBus.valid) begin
			for (int k = 0; k < COEFF_LENGTH - 1; k++) begin
				lineRe[k] <= windowRe[k];
				lineIm[k] <= windowIm[k];
			end
			for (int k = 0; k < COEFF_LENGTH; k++) begin
				prodRe[k] <= taps[k].re * windowRe[k] - taps[k].im * windowIm[k];
				prodIm[k] <= taps[k].re * windowIm[k] + taps[k].im * windowRe[k];
			end
		end
		if (prodValid) begin
			outBus.re <= sumRe;
			outBus.im <= sumIm;
		end
	end

endmodule

// File: rtl/hilbertTransform.sv
`timescale 1ns/1ps

module hilbertTransform import matchedFilterPkg::*; (
	input  logic clock,
	input  logic rst,
	input  logic strobe,
	input  logic last,
	input  logic signed [DATA_WIDTH-1:0] sample,
	sampleBus.producer analytic
);

	localparam int HT_LENGTH = 7;
	localparam int HT_CENTER = 3;
	localparam int HT_SHIFT = 6;
	localparam int SUM_WIDTH = DATA_WIDTH + 8;
	// Odd-symmetric Hilbert taps in 1/64 units. Tap k weights the sample k steps back.
	localparam int HT_TAPS [HT_LENGTH] = '{-14, 0, -41, 0, 41, 0, 14};

	logic signed [DATA_WIDTH-1:0] delayLine [HT_LENGTH];
	logic signed [SUM_WIDTH-1:0] imagSum;
	logic awaitingStart;
	logic lineValid;
	logic lineLast;

	always_comb begin
		imagSum = '0;
		for (int k = 0; k < HT_LENGTH; k++) begin
			imagSum = imagSum + SUM_WIDTH'(HT_TAPS[k]) * delayLine[k];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			awaitingStart <= 1'b1;
			lineValid <= 1'b0;
			lineLast <= 1'b0;
			analytic.valid <= 1'b0;
			analytic.last <= 1'b0;
		end else begin
			// The first strobe after a last starts a new block with an empty history.
			if (strobe) begin
				awaitingStart <= last;
			end
			lineValid <= strobe;
			lineLast <= strobe && last;
			analytic.valid <= lineValid;
			analytic.last <= lineValid && lineLast;
		end
	end

	always_ff @(posedge clock) begin
		if (strobe) begin
			delayLine[0] <= sample;
			for (int k = 1; k < HT_LENGTH; k++) begin
				delayLine[k] <= awaitingStart ? '0 : delayLine[k-1];
			end
		end
		// The real part is the center tap, which lines the two parts up in time.
		if (lineValid) begin
			analytic.re <= HT_WIDTH'(delayLine[HT_CENTER]);
			analytic.im <= HT_WIDTH'(imagSum >>> HT_SHIFT);
		end
	end

endmodule

// File: rtl/matchedFilterControl.sv
`timescale 1ns/1ps

module matchedFilterControl import matchedFilterPkg::*; #(
	parameter int COEFF_LENGTH = 8,
	parameter int DATA_LENGTH = 24
)(
	input  logic clock,
	input  logic rst,
	input  logic start,
	input  logic outLast,
	output logic coeffReadEnable,
	output logic [addrWidth(COEFF_LENGTH)-1:0] coeffReadAddress,
	output logic sampleReadEnable,
	output logic [addrWidth(DATA_LENGTH)-1:0] sampleReadAddress,
	output logic tapLoad,
	output logic sampleStrobe,
	output logic sampleLast,
	output logic busy,
	output logic done
);

	localparam int COEFF_ADDR_WIDTH = addrWidth(COEFF_LENGTH);
	localparam int SAMPLE_ADDR_WIDTH = addrWidth(DATA_LENGTH);
	// The coefficient counter runs one step past the last address to cover the read latency.
	localparam int COEFF_COUNT_WIDTH = $clog2(COEFF_LENGTH + 1);

	mfState_t state;
	logic [COEFF_COUNT_WIDTH-1:0] coeffCount;
	logic [SAMPLE_ADDR_WIDTH-1:0] sampleCount;
	logic coeffCountEnd;
	logic lastSampleRead;

	assign coeffCountEnd = (coeffCount == COEFF_COUNT_WIDTH'(COEFF_LENGTH));
	assign lastSampleRead = (sampleCount == SAMPLE_ADDR_WIDTH'(DATA_LENGTH - 1));

	assign coeffReadEnable = (state == TRANSFER_COEFF) && !coeffCountEnd;
	assign coeffReadAddress = coeffCount[COEFF_ADDR_WIDTH-1:0];
	assign sampleReadEnable = (state == STREAM);
	assign sampleReadAddress = sampleCount;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= IDLE;
			coeffCount <= '0;
			sampleCount <= '0;
			tapLoad <= 1'b0;
			sampleStrobe <= 1'b0;
			sampleLast <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			// Store data arrives one cycle after the read, so the strobes follow by one cycle.
			tapLoad <= coeffReadEnable;
			sampleStrobe <= sampleReadEnable;
			sampleLast <= sampleReadEnable && lastSampleRead;
			done <= 1'b0;

			case (state)
				IDLE: begin
					if (start) begin
						state <= TRANSFER_COEFF;
						coeffCount <= '0;
						busy <= 1'b1;
					end
				end
				TRANSFER_COEFF: begin
					if (coeffCountEnd) begin
						state <= STREAM;
						sampleCount <= '0;
					end else begin
						coeffCount <= coeffCount + 1'b1;
					end
				end
				STREAM: begin
					if (lastSampleRead) begin
						state <= DRAIN;
					end else begin
						sampleCount <= sampleCount + 1'b1;
					end
				end
				DRAIN: begin
					// The last magnitude has left the pipeline, so the block is free again.
					if (outLast) begin
						state <= IDLE;
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: rtl/blockStore.sv
`timescale 1ns/1ps

module blockStore import matchedFilterPkg::*; #(
	parameter int LENGTH = 8,
	parameter type payload_t = coeffPair_t
)(
	input  logic clock,
	input  logic rst,
	input  logic write,
	input  payload_t writeData,
	input  logic readEnable,
	input  logic [addrWidth(LENGTH)-1:0] readAddress,
	output payload_t readData,
	input  logic clear
);

	localparam int ADDR_WIDTH = addrWidth(LENGTH);

	payload_t memory [LENGTH];
	logic [ADDR_WIDTH-1:0] writePointer;
	logic writePointerEnd;

	assign writePointerEnd = (writePointer == ADDR_WIDTH'(LENGTH - 1));

	// The host fills the buffer in order. The pointer wraps, and done starts the next block at zero.
	always_ff @(posedge clock) begin
		if (rst || clear) begin
			writePointer <= '0;
		end else if (write) begin
			if (writePointerEnd) begin
				writePointer <= '0;
			end else begin
				writePointer <= writePointer + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (write && !clear) begin
			memory[writePointer] <= writeData;
		end
	end

	// Registered read with one cycle of latency.
	always_ff @(posedge clock) begin
		if (readEnable) begin
			readData <= memory[readAddress];
		end
	end

endmodule

// File: common/sampleBus.sv
`timescale 1ns/1ps

// One complex sample per cycle between pipeline stages.
// There is no back-pressure, so a sample moves on every cycle with valid high.
interface sampleBus #(
	parameter int WIDTH = 18
);

	logic valid;
	logic last;
	logic signed [WIDTH-1:0] re;
	logic signed [WIDTH-1:0] im;

	modport producer (
		output valid,
		output last,
		output re,
		output im
	);

	modport consumer (
		input valid,
		input last,
		input re,
		input im
	);

endinterface

// File: common/matchedFilterPkg.sv
package matchedFilterPkg;

	// Input sample and coefficient width.
	localparam int DATA_WIDTH = 16;

	// The Hilbert tap magnitudes add up to 110/64, so two extra bits cover every result.
	localparam int HT_WIDTH = 18;

	// Accumulator width of the complex FIR, also used on its output bus.
	localparam int ACC_WIDTH = 40;

	// The L1 magnitude is the sum of two absolute values, so it needs one more bit.
	localparam int MAG_WIDTH = ACC_WIDTH + 1;

	// One complex reference coefficient as the host writes it.
	typedef struct packed {
		logic signed [DATA_WIDTH-1:0] re;
		logic signed [DATA_WIDTH-1:0] im;
	} coeffPair_t;

	// Control FSM states.
	typedef enum logic [1:0] {
		IDLE,
		TRANSFER_COEFF,
		STREAM,
		DRAIN
	} mfState_t;

	// Address width for a buffer of the given length, never below one bit.
	function automatic int addrWidth(input int length);
		int width;
		width = 1;
		if (length > 1) begin
			width = $clog2(length);
		end
		return width;
	endfunction

endpackage
